//--- hdl/fpu_cfg.svh
/* Sizes of the FPU subsystem. The queue depth must be a power of two because the
   queue pointers wrap naturally. It is also the credit count the core starts with */
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

`define FPU_QUEUE_DEPTH 4   // Issue queue entries and initial credits
`define FPU_REG_COUNT   32  // Floating-point registers
`define FPU_DATA_WIDTH  64  // Double precision word

`endif

//--- hdl/fpu_compare_lane.sv
/* Two-stage pipelined FEQ/FLT/FLE/FMIN/FMAX for doubles with IEEE NaN and signed-zero
   rules. Two NaNs into FMIN/FMAX give the canonical quiet NaN */
`timescale 1ns/10ps

module fpu_compare_lane (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmp_go,
    input  fpu_pkg::fp_op_e    op,
    input  fpu_pkg::reg_addr_t rd,
    input  fpu_pkg::fp_word_t  opa,
    input  fpu_pkg::fp_word_t  opb,
    output logic               cmp_done,
    output fpu_pkg::fp_word_t  cmp_result,
    output fpu_pkg::reg_addr_t cmp_rd,
    output logic               cmp_int_dest,
    output fpu_pkg::fp_flags_t cmp_flags
);

    logic a_nan, b_nan, a_lt_b, a_eq_b;
    logic s1_valid, s1_a_nan, s1_b_nan, s1_snan, s1_lt, s1_eq;
    fpu_pkg::fp_op_e    s1_op;
    fpu_pkg::reg_addr_t s1_rd;
    fpu_pkg::fp_word_t  s1_a, s1_b, result;
    logic any_nan, invalid;

    assign a_nan  = (&opa[62:52]) && (|opa[51:0]);
    assign b_nan  = (&opb[62:52]) && (|opb[51:0]);
    assign a_eq_b = (opa == opb) || (opa[62:0] == '0 && opb[62:0] == '0); // +0 equals -0
    // Total order on the sign and magnitude, -0 below +0
    assign a_lt_b = (opa[63] != opb[63]) ? opa[63] :
                    opa[63] ? (opa[62:0] > opb[62:0]) : (opa[62:0] < opb[62:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            cmp_done <= 1'b0;
        end else begin
            s1_valid <= cmp_go;
            cmp_done <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmp_go) begin
            s1_op    <= op;
            s1_rd    <= rd;
            s1_a     <= opa;
            s1_b     <= opb;
            s1_a_nan <= a_nan;
            s1_b_nan <= b_nan;
            s1_snan  <= (a_nan && !opa[51]) || (b_nan && !opb[51]);
            s1_lt    <= a_lt_b;
            s1_eq    <= a_eq_b;
        end
    end

    assign any_nan = s1_a_nan || s1_b_nan;

    always_comb begin
        result  = '0;
        invalid = s1_snan;
        case (s1_op)
            fpu_pkg::EQ: result[0] = !any_nan && s1_eq;
            fpu_pkg::LT: begin
                result[0] = !any_nan && s1_lt && !s1_eq;
                invalid   = any_nan; // Signaling compare
            end
            fpu_pkg::LE: begin
                result[0] = !any_nan && (s1_lt || s1_eq);
                invalid   = any_nan;
            end
            fpu_pkg::MIN, fpu_pkg::MAX: begin
                if (s1_a_nan && s1_b_nan) result = 64'h7FF8_0000_0000_0000;
                else if (s1_a_nan)       result = s1_b;
                else if (s1_b_nan)       result = s1_a;
                else result = ((s1_op == fpu_pkg::MIN) == s1_lt) ? s1_a : s1_b;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            cmp_result   <= result;
            cmp_rd       <= s1_rd;
            cmp_int_dest <= s1_op inside {fpu_pkg::EQ, fpu_pkg::LT, fpu_pkg::LE};
            cmp_flags    <= {invalid, 4'b0000};
        end
    end

endmodule

//--- hdl/fpu_decoder.sv
/* In-order decode and dispatch of D-extension compare, sign and move instructions.
   Anything else is popped and dropped; integer destinations are not tracked */
`timescale 1ns/10ps
`include "fpu_cfg.svh"

module fpu_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               q_valid,
    input  fpu_pkg::inst_t     q_inst,
    input  fpu_pkg::fp_word_t  q_data,
    output logic               q_pop,
    output fpu_pkg::reg_addr_t rs1_addr,
    output fpu_pkg::reg_addr_t rs2_addr,
    input  fpu_pkg::fp_word_t  rs1_data,
    input  fpu_pkg::fp_word_t  rs2_data,
    input  logic               wr_en,
    input  fpu_pkg::reg_addr_t wr_addr,
    output logic               sign_go,
    output logic               cmp_go,
    output fpu_pkg::fp_op_e    op,
    output fpu_pkg::reg_addr_t rd,
    output fpu_pkg::fp_word_t  opa,
    output fpu_pkg::fp_word_t  opb
);

    fpu_pkg::fp_op_e     dec_op;
    fpu_pkg::dec_state_e state;
    fpu_pkg::reg_addr_t  dec_rd;
    logic [`FPU_REG_COUNT-1:0] busy; // Pending FP writes
    logic use_rs1, use_rs2, fp_dest, is_sign, is_cmp, hazard;

    assign rs1_addr = q_inst[19:15];
    assign rs2_addr = q_inst[24:20];
    assign dec_rd   = q_inst[11:7];

    always_comb begin
        dec_op = fpu_pkg::ILLEGAL;
        if (q_inst[6:0] == 7'b1010011) begin // OP-FP, fmt D in funct7[1:0]
            case (q_inst[31:25])
                7'b0010001: case (q_inst[14:12])
                    3'b000: dec_op = fpu_pkg::SGNJ;
                    3'b001: dec_op = fpu_pkg::SGNJN;
                    3'b010: dec_op = fpu_pkg::SGNJX;
                    default: ;
                endcase
                7'b0010101: case (q_inst[14:12])
                    3'b000: dec_op = fpu_pkg::MIN;
                    3'b001: dec_op = fpu_pkg::MAX;
                    default: ;
                endcase
                7'b1010001: case (q_inst[14:12])
                    3'b010: dec_op = fpu_pkg::EQ;
                    3'b001: dec_op = fpu_pkg::LT;
                    3'b000: dec_op = fpu_pkg::LE;
                    default: ;
                endcase
                7'b1110001: if (rs2_addr == '0) begin
                    if (q_inst[14:12] == 3'b000) dec_op = fpu_pkg::MV_X;
                    else if (q_inst[14:12] == 3'b001) dec_op = fpu_pkg::CLASS;
                end
                7'b1111001: if (rs2_addr == '0 && q_inst[14:12] == 3'b000) begin
                    dec_op = fpu_pkg::MV_D;
                end
                default: ;
            endcase
        end
    end

    assign is_sign = dec_op inside {fpu_pkg::SGNJ, fpu_pkg::SGNJN, fpu_pkg::SGNJX,
                                    fpu_pkg::MV_X, fpu_pkg::MV_D, fpu_pkg::CLASS};
    assign is_cmp  = dec_op inside {fpu_pkg::EQ, fpu_pkg::LT, fpu_pkg::LE,
                                    fpu_pkg::MIN, fpu_pkg::MAX};
    assign use_rs1 = is_cmp || (is_sign && dec_op != fpu_pkg::MV_D);
    assign use_rs2 = is_cmp || dec_op inside {fpu_pkg::SGNJ, fpu_pkg::SGNJN, fpu_pkg::SGNJX};
    assign fp_dest = dec_op inside {fpu_pkg::SGNJ, fpu_pkg::SGNJN, fpu_pkg::SGNJX,
                                    fpu_pkg::MV_D, fpu_pkg::MIN, fpu_pkg::MAX};

    // Sign lane would finish together with the compare just dispatched
    assign hazard = (use_rs1 && busy[rs1_addr]) || (use_rs2 && busy[rs2_addr])
                  || (fp_dest && busy[dec_rd]) || (is_sign && cmp_go);
    assign q_pop  = q_valid && !hazard;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= '0;
            sign_go <= 1'b0;
            cmp_go  <= 1'b0;
            state   <= fpu_pkg::IDLE;
        end else begin
            sign_go <= q_pop && is_sign;
            cmp_go  <= q_pop && is_cmp;
            state   <= (q_valid && hazard) ? fpu_pkg::STALL : fpu_pkg::IDLE;
            if (wr_en) busy[wr_addr] <= 1'b0;
            if (q_pop && fp_dest) busy[dec_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            op  <= dec_op;
            rd  <= dec_rd;
            opa <= (dec_op == fpu_pkg::MV_D) ? q_data : rs1_data; // FMV.D.X reads the core
            opb <= rs2_data;
        end
    end

    a_one_lane: assert property (@(posedge clk) disable iff (!rst_n) !(sign_go && cmp_go));
    // A stall ends once the slowest lane has written back
    a_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        state == fpu_pkg::STALL |-> ##[1:4] state == fpu_pkg::IDLE);

endmodule

//--- hdl/fpu_issue_queue.sv
/* Instruction and operand FIFO behind the credit port. The core may only send while it
   holds a credit, so the queue never has to refuse a beat */
`timescale 1ns/10ps
`include "fpu_cfg.svh"

module fpu_issue_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cp_valid,
    input  fpu_pkg::inst_t     cp_inst,
    input  fpu_pkg::fp_word_t  cp_data,
    input  logic               q_pop,
    output logic               q_valid,
    output fpu_pkg::inst_t     q_inst,
    output fpu_pkg::fp_word_t  q_data,
    output logic               cp_credit
);

    fpu_pkg::inst_t    inst_mem [`FPU_QUEUE_DEPTH];
    fpu_pkg::fp_word_t data_mem [`FPU_QUEUE_DEPTH];
    logic [$clog2(`FPU_QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(`FPU_QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(`FPU_QUEUE_DEPTH):0]   count;

    assign q_valid   = (count != '0);
    assign q_inst    = inst_mem[rd_ptr];
    assign q_data    = data_mem[rd_ptr];
    assign cp_credit = q_pop; // Every pop frees one slot

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cp_valid) wr_ptr <= wr_ptr + 1'b1;
            if (q_pop) rd_ptr <= rd_ptr + 1'b1;
            if (cp_valid && !q_pop) count <= count + 1'b1;
            else if (!cp_valid && q_pop) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cp_valid) begin
            inst_mem[wr_ptr] <= cp_inst;
            data_mem[wr_ptr] <= cp_data;
        end
    end

    // The core overran its credits
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        cp_valid |-> (count < `FPU_QUEUE_DEPTH) || q_pop);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        q_pop |-> q_valid);

endmodule

//--- hdl/fpu_pkg.sv
/* Types shared by the FPU subsystem. Only the invalid bit of the flag vector is ever
   raised, because this subsystem has no arithmetic */
`include "fpu_cfg.svh"

package fpu_pkg;

    typedef logic [`FPU_DATA_WIDTH-1:0] fp_word_t;  // Double or integer word
    typedef logic [31:0]                inst_t;     // RISC-V instruction word
    typedef logic [4:0]                 reg_addr_t; // Register index
    typedef logic [4:0]                 fp_flags_t; // NV DZ OF UF NX
    typedef logic [9:0]                 class_mask_t; // FCLASS result bits

    // Operations dispatched to the lanes
    typedef enum logic [3:0] {
        SGNJ,
        SGNJN,
        SGNJX,
        MV_X,
        MV_D,
        CLASS,
        EQ,
        LT,
        LE,
        MIN,
        MAX,
        ILLEGAL
    } fp_op_e;

    typedef enum logic {
        IDLE,
        STALL
    } dec_state_e;

endpackage

//--- hdl/fpu_regfile.sv
/* Floating-point registers with combinational reads. A read in the cycle of a write to
   the same register returns the old value */
`timescale 1ns/10ps
`include "fpu_cfg.svh"

module fpu_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  fpu_pkg::reg_addr_t rs1_addr,
    input  fpu_pkg::reg_addr_t rs2_addr,
    output fpu_pkg::fp_word_t  rs1_data,
    output fpu_pkg::fp_word_t  rs2_data,
    input  logic               wr_en,
    input  fpu_pkg::reg_addr_t wr_addr,
    input  fpu_pkg::fp_word_t  wr_data
);

    fpu_pkg::fp_word_t regs [`FPU_REG_COUNT];

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FPU_REG_COUNT; i++) regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- hdl/fpu_sign_lane.sv
/* Sign injection, raw moves and FCLASS.D with one register stage.
   Raises no exception flags */
`timescale 1ns/10ps

module fpu_sign_lane (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sign_go,
    input  fpu_pkg::fp_op_e    op,
    input  fpu_pkg::reg_addr_t rd,
    input  fpu_pkg::fp_word_t  opa,
    input  fpu_pkg::fp_word_t  opb,
    output logic               sign_done,
    output fpu_pkg::fp_word_t  sign_result,
    output fpu_pkg::reg_addr_t sign_rd,
    output logic               sign_int_dest
);

    fpu_pkg::class_mask_t cls;
    fpu_pkg::fp_word_t    result;
    logic exp_ones, exp_zero, frac_zero, neg;

    assign neg       = opa[63];
    assign exp_ones  = &opa[62:52];
    assign exp_zero  = ~|opa[62:52];
    assign frac_zero = ~|opa[51:0];

    always_comb begin
        cls    = '0;
        cls[0] = neg && exp_ones && frac_zero;   // -inf
        cls[1] = neg && !exp_ones && !exp_zero;  // -normal
        cls[2] = neg && exp_zero && !frac_zero;  // -subnormal
        cls[3] = neg && exp_zero && frac_zero;
        cls[4] = !neg && exp_zero && frac_zero;
        cls[5] = !neg && exp_zero && !frac_zero;
        cls[6] = !neg && !exp_ones && !exp_zero;
        cls[7] = !neg && exp_ones && frac_zero;
        cls[8] = exp_ones && !frac_zero && !opa[51]; // Signaling NaN
        cls[9] = exp_ones && opa[51];                // Quiet NaN
    end

    always_comb begin
        case (op)
            fpu_pkg::SGNJ:  result = {opb[63], opa[62:0]};
            fpu_pkg::SGNJN: result = {~opb[63], opa[62:0]};
            fpu_pkg::SGNJX: result = {opa[63] ^ opb[63], opa[62:0]};
            fpu_pkg::CLASS: result = fpu_pkg::fp_word_t'(cls);
            default:        result = opa; // Both moves pass the bits through
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) sign_done <= 1'b0;
        else        sign_done <= sign_go;
    end

    always_ff @(posedge clk) begin
        if (sign_go) begin
            sign_result   <= result;
            sign_rd       <= rd;
            sign_int_dest <= (op == fpu_pkg::MV_X) || (op == fpu_pkg::CLASS);
        end
    end

endmodule

//--- hdl/fpu_top.sv
/* Double-precision sign, move, classify and compare coprocessor. Results cannot be
   back-pressured; issue is bounded only by credits */
`timescale 1ns/10ps

module fpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cp_valid,
    input  fpu_pkg::inst_t     cp_inst,
    input  fpu_pkg::fp_word_t  cp_data,
    output logic               cp_credit,
    output logic               cp_result_valid,
    output fpu_pkg::reg_addr_t cp_result_rd,
    output fpu_pkg::fp_word_t  cp_result_data,
    output fpu_pkg::fp_flags_t cp_flags
);

    logic               q_valid, q_pop;
    fpu_pkg::inst_t     q_inst;
    fpu_pkg::fp_word_t  q_data;
    fpu_pkg::reg_addr_t rs1_addr, rs2_addr, rd, wr_addr;
    fpu_pkg::fp_word_t  rs1_data, rs2_data, opa, opb, wr_data;
    fpu_pkg::fp_op_e    op;
    logic               sign_go, cmp_go, wr_en;
    logic               sign_done, sign_int_dest, cmp_done, cmp_int_dest;
    fpu_pkg::fp_word_t  sign_result, cmp_result;
    fpu_pkg::reg_addr_t sign_rd, cmp_rd;
    fpu_pkg::fp_flags_t cmp_flags;

    fpu_issue_queue u_queue (
        .clk(clk), .rst_n(rst_n),
        .cp_valid(cp_valid), .cp_inst(cp_inst), .cp_data(cp_data),
        .q_pop(q_pop), .q_valid(q_valid), .q_inst(q_inst), .q_data(q_data),
        .cp_credit(cp_credit)
    );

    fpu_decoder u_decoder (
        .clk(clk), .rst_n(rst_n),
        .q_valid(q_valid), .q_inst(q_inst), .q_data(q_data), .q_pop(q_pop),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr),
        .sign_go(sign_go), .cmp_go(cmp_go),
        .op(op), .rd(rd), .opa(opa), .opb(opb)
    );

    fpu_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    fpu_sign_lane u_sign (
        .clk(clk), .rst_n(rst_n),
        .sign_go(sign_go), .op(op), .rd(rd), .opa(opa), .opb(opb),
        .sign_done(sign_done), .sign_result(sign_result),
        .sign_rd(sign_rd), .sign_int_dest(sign_int_dest)
    );

    fpu_compare_lane u_compare (
        .clk(clk), .rst_n(rst_n),
        .cmp_go(cmp_go), .op(op), .rd(rd), .opa(opa), .opb(opb),
        .cmp_done(cmp_done), .cmp_result(cmp_result), .cmp_rd(cmp_rd),
        .cmp_int_dest(cmp_int_dest), .cmp_flags(cmp_flags)
    );

    fpu_writeback u_writeback (
        .clk(clk), .rst_n(rst_n),
        .sign_done(sign_done), .sign_result(sign_result),
        .sign_rd(sign_rd), .sign_int_dest(sign_int_dest),
        .cmp_done(cmp_done), .cmp_result(cmp_result),
        .cmp_rd(cmp_rd), .cmp_int_dest(cmp_int_dest), .cmp_flags(cmp_flags),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .cp_result_valid(cp_result_valid), .cp_result_rd(cp_result_rd),
        .cp_result_data(cp_result_data), .cp_flags(cp_flags)
    );

endmodule

//--- hdl/fpu_writeback.sv
/* Merges the two lanes. The decoder keeps them from finishing in the same cycle,
   and the core always takes integer results */
`timescale 1ns/10ps

module fpu_writeback (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sign_done,
    input  fpu_pkg::fp_word_t  sign_result,
    input  fpu_pkg::reg_addr_t sign_rd,
    input  logic               sign_int_dest,
    input  logic               cmp_done,
    input  fpu_pkg::fp_word_t  cmp_result,
    input  fpu_pkg::reg_addr_t cmp_rd,
    input  logic               cmp_int_dest,
    input  fpu_pkg::fp_flags_t cmp_flags,
    output logic               wr_en,
    output fpu_pkg::reg_addr_t wr_addr,
    output fpu_pkg::fp_word_t  wr_data,
    output logic               cp_result_valid,
    output fpu_pkg::reg_addr_t cp_result_rd,
    output fpu_pkg::fp_word_t  cp_result_data,
    output fpu_pkg::fp_flags_t cp_flags
);

    logic sel_int, int_done;

    assign sel_int  = sign_done ? sign_int_dest : cmp_int_dest;
    assign int_done = (sign_done || cmp_done) && sel_int;

    assign wr_en   = (sign_done || cmp_done) && !sel_int; // Lands at the next edge
    assign wr_addr = sign_done ? sign_rd : cmp_rd;
    assign wr_data = sign_done ? sign_result : cmp_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cp_result_valid <= 1'b0;
            cp_flags        <= '0;
        end else begin
            cp_result_valid <= int_done;
            if (cmp_done) cp_flags <= cp_flags | cmp_flags; // Sticky
        end
    end

    always_ff @(posedge clk) begin
        if (int_done) begin
            cp_result_rd   <= wr_addr;
            cp_result_data <= wr_data;
        end
    end

    a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(sign_done && cmp_done));

endmodule

//--- list.f
+incdir+hdl
+incdir+testbench
hdl/fpu_pkg.sv
hdl/fpu_issue_queue.sv
hdl/fpu_decoder.sv
hdl/fpu_regfile.sv
hdl/fpu_sign_lane.sv
hdl/fpu_compare_lane.sv
hdl/fpu_writeback.sv
hdl/fpu_top.sv
testbench/fpu_clock_gen.sv
testbench/fpu_tb.sv

//--- testbench/fpu_clock_gen.sv
/* Free-running 40 ns clock and an active-low reset held for 3 cycles */
`timescale 1ns/10ps

module fpu_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk); // Release away from the active edge
        rst_n = 1'b1;
    end

endmodule

//--- testbench/fpu_ref_model.svh
/* Reference model, included inside the testbench top. It runs each instruction at issue
   in program order and queues the integer results the core should receive */
`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

fpu_pkg::fp_word_t  model_regs [`FPU_REG_COUNT];
fpu_pkg::fp_flags_t model_flags;
fpu_pkg::reg_addr_t exp_rd [$];   // Expected integer results, oldest first
fpu_pkg::fp_word_t  exp_data [$];

task automatic model_reset();
    for (int i = 0; i < `FPU_REG_COUNT; i++) begin
        model_regs[i] = '0;
    end
    model_flags = '0;
endtask

function automatic logic is_nan(input fpu_pkg::fp_word_t v);
    return (v[62:52] == 11'h7ff) && (v[51:0] != 52'h0);
endfunction

function automatic logic is_snan(input fpu_pkg::fp_word_t v);
    return is_nan(v) && !v[51]; // Quiet bit clear
endfunction

// Signed number line position, both zeros land on 0
function automatic logic signed [64:0] order_key(input fpu_pkg::fp_word_t v);
    logic signed [64:0] mag;
    mag = {2'b00, v[62:0]};
    return v[63] ? -mag : mag;
endfunction

function automatic fpu_pkg::class_mask_t class_of(input fpu_pkg::fp_word_t v);
    fpu_pkg::class_mask_t m;
    int                   idx;
    m = '0;
    if (is_nan(v)) idx = v[51] ? 9 : 8;
    else if (v[62:52] == 11'h7ff) idx = v[63] ? 0 : 7; // Infinities
    else if (v[62:52] != 11'h000) idx = v[63] ? 1 : 6;
    else if (v[51:0] != 52'h0) idx = v[63] ? 2 : 5;   // Subnormals
    else idx = v[63] ? 3 : 4;
    m[idx] = 1'b1;
    return m;
endfunction

// RV64D encodings of the supported subset
function automatic fpu_pkg::fp_op_e decode_op(input fpu_pkg::inst_t inst);
    logic [2:0] f3;
    logic       rs2_zero;
    f3       = inst[14:12];
    rs2_zero = (inst[24:20] == 5'd0);
    if (inst[6:0] == 7'b1010011) begin
        case (inst[31:25])
            7'h11: if (f3 == 3'd0) return fpu_pkg::SGNJ;
                   else if (f3 == 3'd1) return fpu_pkg::SGNJN;
                   else if (f3 == 3'd2) return fpu_pkg::SGNJX;
            7'h15: if (f3 == 3'd0) return fpu_pkg::MIN;
                   else if (f3 == 3'd1) return fpu_pkg::MAX;
            7'h51: if (f3 == 3'd2) return fpu_pkg::EQ;
                   else if (f3 == 3'd1) return fpu_pkg::LT;
                   else if (f3 == 3'd0) return fpu_pkg::LE;
            7'h71: if (rs2_zero && f3 == 3'd0) return fpu_pkg::MV_X;
                   else if (rs2_zero && f3 == 3'd1) return fpu_pkg::CLASS;
            7'h79: if (rs2_zero && f3 == 3'd0) return fpu_pkg::MV_D;
            default: ;
        endcase
    end
    return fpu_pkg::ILLEGAL;
endfunction

task automatic model_exec(input fpu_pkg::inst_t inst, input fpu_pkg::fp_word_t data);
    fpu_pkg::fp_op_e    kind;
    fpu_pkg::fp_word_t  a, b;
    fpu_pkg::reg_addr_t rd;
    logic               any_nan, a_less;
    kind    = decode_op(inst);
    a       = model_regs[inst[19:15]];
    b       = model_regs[inst[24:20]];
    rd      = inst[11:7];
    any_nan = is_nan(a) || is_nan(b);
    if (kind inside {fpu_pkg::EQ, fpu_pkg::LT, fpu_pkg::LE, fpu_pkg::MIN, fpu_pkg::MAX}) begin
        if (is_snan(a) || is_snan(b) || (any_nan && kind inside {fpu_pkg::LT, fpu_pkg::LE}))
            model_flags[4] = 1'b1; // Invalid
    end
    case (kind)
        fpu_pkg::SGNJ:  model_regs[rd] = {b[63], a[62:0]};
        fpu_pkg::SGNJN: model_regs[rd] = {~b[63], a[62:0]};
        fpu_pkg::SGNJX: model_regs[rd] = {a[63] ^ b[63], a[62:0]};
        fpu_pkg::MV_D:  model_regs[rd] = data;
        fpu_pkg::MV_X, fpu_pkg::CLASS, fpu_pkg::EQ, fpu_pkg::LT, fpu_pkg::LE: begin
            exp_rd.push_back(rd);
            if (kind == fpu_pkg::MV_X) exp_data.push_back(a);
            else if (kind == fpu_pkg::CLASS) exp_data.push_back(fpu_pkg::fp_word_t'(class_of(a)));
            else if (kind == fpu_pkg::EQ) exp_data.push_back(!any_nan && order_key(a) == order_key(b));
            else if (kind == fpu_pkg::LT) exp_data.push_back(!any_nan && order_key(a) < order_key(b));
            else exp_data.push_back(!any_nan && order_key(a) <= order_key(b));
        end
        fpu_pkg::MIN, fpu_pkg::MAX: begin
            a_less = (order_key(a) < order_key(b)) || (order_key(a) == order_key(b) && a[63]);
            if (is_nan(a) && is_nan(b)) model_regs[rd] = 64'h7ff8_0000_0000_0000;
            else if (is_nan(a)) model_regs[rd] = b;
            else if (is_nan(b)) model_regs[rd] = a;
            else model_regs[rd] = ((kind == fpu_pkg::MIN) == a_less) ? a : b;
        end
        default: ; // Illegal, consumed with no effect
    endcase
endtask

`endif

//--- testbench/fpu_tb.sv
/* Random testbench for the FPU subsystem with a model that runs at issue time.
   Stops at the first mismatch; integer results are expected in issue order */
`timescale 1ns/10ps
`include "fpu_cfg.svh"

module fpu_tb;

    localparam int NUM_RAND    = 300;
    localparam int MAX_INST    = 3 * `FPU_REG_COUNT + 2 * NUM_RAND;
    localparam int WATCHDOG_NS = (40 * MAX_INST + 100) * 40; // 40 cycles per instruction

    logic               clk;
    logic               rst_n;
    logic               cp_valid;
    fpu_pkg::inst_t     cp_inst;
    fpu_pkg::fp_word_t  cp_data;
    logic               cp_credit;
    logic               cp_result_valid;
    fpu_pkg::reg_addr_t cp_result_rd;
    fpu_pkg::fp_word_t  cp_result_data;
    fpu_pkg::fp_flags_t cp_flags;
    int                 credits;    // Beats the core may still send
    fpu_pkg::reg_addr_t last_rd;    // Latest FP destination, for dependent chains
    logic [31:0]        lfsr_state;

    `include "fpu_ref_model.svh"

    fpu_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

    fpu_top uut (
        .clk(clk), .rst_n(rst_n),
        .cp_valid(cp_valid), .cp_inst(cp_inst), .cp_data(cp_data),
        .cp_credit(cp_credit), .cp_result_valid(cp_result_valid),
        .cp_result_rd(cp_result_rd), .cp_result_data(cp_result_data),
        .cp_flags(cp_flags)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input fpu_pkg::reg_addr_t want_rd, got_rd,
                                input fpu_pkg::fp_word_t want_data, got_data);
        if (got_rd !== want_rd)
            abort_run($sformatf("error cp_result_rd expected %h got %h", want_rd, got_rd));
        if (got_data !== want_data)
            abort_run($sformatf("error cp_result_data expected %h got %h", want_data, got_data));
    endtask

    task automatic check_flags(input fpu_pkg::fp_flags_t want, got);
        if (got !== want)
            abort_run($sformatf("error cp_flags expected %h got %h", want, got));
    endtask

    // Right-shifting Galois LFSR, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic fpu_pkg::fp_word_t draw_operand();
        logic [2:0]  kind;
        logic        sgn;
        logic [10:0] ex;
        logic [51:0] frac;
        kind = rand_bits(3);
        sgn  = rand_bits(1);
        ex   = rand_bits(11);
        frac = rand_bits(52);
        if (ex == 11'h000 || ex == 11'h7ff) ex = 11'h3ff; // Keep normals normal
        case (kind)
            3'd0, 3'd1: return {kind[0], 63'h0};
            3'd2:       return {sgn, 11'h7ff, 52'h0};                 // Infinity
            3'd3:       return {sgn, 11'h7ff, 1'b1, frac[50:0]};      // Quiet NaN
            3'd4:       return {sgn, 11'h7ff, 1'b0, frac[50:1], 1'b1}; // Signaling NaN
            3'd5:       return {sgn, 11'h000, frac[51:1], 1'b1};      // Subnormal
            default:    return {sgn, ex, frac};
        endcase
    endfunction

    function automatic fpu_pkg::inst_t encode(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b1010011};
    endfunction

    function automatic fpu_pkg::inst_t illegal_word();
        fpu_pkg::inst_t w;
        w = rand_bits(32);
        if (rand_bits(1)) w[6:0] = 7'b1010011; // Inside OP-FP
        if (decode_op(w) != fpu_pkg::ILLEGAL) w[25] = 1'b0; // Single precision
        return w;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        cp_valid = 1'b0;
        if (cp_credit) credits++;
        if (credits > `FPU_QUEUE_DEPTH) abort_run("more credits returned than beats sent");
    endtask

    task automatic send(input fpu_pkg::inst_t inst, input fpu_pkg::fp_word_t data);
        while (credits == 0) next_cycle();
        cp_valid = 1'b1;
        cp_inst  = inst;
        cp_data  = data;
        credits--;
        model_exec(inst, data);
        next_cycle();
    endtask

    task automatic random_item();
        logic [2:0]         kind;
        logic [2:0]         f3;
        fpu_pkg::reg_addr_t rd, rs1, rs2, xd;
        kind = rand_bits(3);
        f3   = rand_bits(2);
        rd   = rand_bits(5);
        rs1  = rand_bits(5);
        rs2  = rand_bits(5);
        xd   = rand_bits(5);
        if (rand_bits(1)) rs1 = last_rd; // Read the previous FP result
        case (kind)
            3'd0, 3'd1: begin
                send(encode(7'h11, rs2, rs1, (f3 == 3'd3) ? 3'd0 : f3, rd), '0);
                send(encode(7'h71, 5'd0, rd, 3'b000, xd), '0);
                last_rd = rd;
            end
            3'd2: send(encode(7'h71, 5'd0, rs1, 3'b001, xd), '0); // FCLASS.D
            3'd3, 3'd4: send(encode(7'h51, rs2, rs1, (f3 == 3'd3) ? 3'd2 : f3, xd), '0);
            3'd5: begin
                send(encode(7'h15, rs2, rs1, {2'b00, f3[0]}, rd), '0);
                send(encode(7'h71, 5'd0, rd, 3'b000, xd), '0);
                last_rd = rd;
            end
            3'd6: begin
                send(encode(7'h79, 5'd0, 5'd0, 3'b000, rd), draw_operand());
                last_rd = rd;
            end
            default: send(illegal_word(), rand_bits(64));
        endcase
    endtask

    initial begin
        cp_valid   = 1'b0;
        cp_inst    = '0;
        cp_data    = '0;
        credits    = `FPU_QUEUE_DEPTH;
        last_rd    = '0;
        lfsr_state = 32'h0ed5_42a4;
        model_reset();
        @(posedge rst_n);
        for (int r = 0; r < `FPU_REG_COUNT; r++) begin
            send(encode(7'h79, 5'd0, 5'd0, 3'b000, 5'(r)), draw_operand());
        end
        for (int r = 0; r < `FPU_REG_COUNT; r++) begin
            send(encode(7'h71, 5'd0, 5'(r), 3'b000, 5'(rand_bits(5))), '0);
        end
        repeat (NUM_RAND) random_item();
        for (int r = 0; r < `FPU_REG_COUNT; r++) begin
            send(encode(7'h71, 5'd0, 5'(r), 3'b000, 5'(r)), '0);
        end
        while (credits != `FPU_QUEUE_DEPTH) next_cycle();
        repeat (6) next_cycle(); // Last pop through to the sticky flags
        check_flags(model_flags, cp_flags);
        if (exp_rd.size() != 0) begin
            abort_run("integer results still missing at the end of the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // Results are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n && cp_result_valid) begin
            if (exp_rd.size() == 0) begin
                abort_run("integer result returned while none was expected");
            end else begin
                check_result(exp_rd[0], cp_result_rd, exp_data[0], cp_result_data);
                exp_rd.delete(0);
                exp_data.delete(0);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog timeout, the run did not complete in time");
    end

endmodule
